/* axi_udp_cmd.f */
hdl/udp_cmd_pkg.sv
hdl/beat_counter.sv
hdl/wr_payload_fifo.sv
hdl/rd_resp_buffer.sv
hdl/cmd_fsm.sv
hdl/axi_udp_cmd.sv
bench/axi_udp_cmd_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = axi_udp_cmd_tb
FILELIST  = axi_udp_cmd.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* bench/axi_udp_cmd_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_udp_cmd_tb;

  localparam int         NUM    = 8;
  localparam logic [3:0] DUT_ID = 4'h0;
  localparam logic [1:0] WR_OP  = 2'b10;
  localparam logic [1:0] RD_OP  = 2'b01;

  // op, word address, length as beat count minus one.
  localparam logic [37:0] CMDS [NUM] = '{
    {WR_OP, 28'h0000010, 8'd15},
    {RD_OP, 28'h0000010, 8'd15},
    {WR_OP, 28'h0000100, 8'd0},
    {2'b00, 28'h0000200, 8'd0},
    {RD_OP, 28'h0000100, 8'd3},
    {2'b11, 28'h0000020, 8'd0},
    {WR_OP, 28'h0000200, 8'd255},
    {RD_OP, 28'h0000280, 8'd31}
  };

  logic        gmii_rx_clk;
  logic        rstn;
  logic [27:0] wr_addr;
  logic [3:0]  wr_ID;
  logic [7:0]  wr_len;
  logic        wr_addr_valid;
  logic        wr_addr_ready;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;
  logic        wr_data_valid;
  logic        wr_data_ready;
  logic        wr_data_last;
  logic [27:0] rd_addr;
  logic [3:0]  rd_ID;
  logic [7:0]  rd_len;
  logic        rd_addr_valid;
  logic        rd_addr_ready;
  logic [31:0] rd_data;
  logic [3:0]  rd_back_ID;
  logic        rd_data_last;
  logic        rd_data_ready;
  logic        rd_data_valid;
  logic        rec_pkt_done;
  logic [31:0] datain;
  logic        rec_en;
  logic        tx_req;
  logic        tx_start_en;
  logic [31:0] udp_tx_data;

  integer      seed;
  int          cycles = 0;
  int          limit = 200;
  int          cur;
  logic [1:0]  cur_op;
  logic [31:0] payload [NUM*256];
  logic [31:0] exp_mem [1024];
  logic [31:0] mem [1024];
  logic [9:0]  wa;
  logic [9:0]  ra;
  int          wbeat;
  int          rbeat;
  int          rlen;
  logic        rd_active;
  logic        rd_xfer;
  int          wr_bursts;
  int          tx_pulses;

  axi_udp_cmd #(.ID(DUT_ID), .FIFO_AW(8)) u_axi_udp_cmd (.*);

  initial begin
    gmii_rx_clk = 1'b0;
    forever #2 gmii_rx_clk = ~gmii_rx_clk;
  end

  always @(posedge gmii_rx_clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout waiting for DUT");
      $display("test failed");
      $fatal(1);
    end
  end

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // header, then payload words or the length word, then the done pulse.
  task automatic send_packet(input int idx);
    int words;
    int j;
    words = (CMDS[idx][37:36] == WR_OP) ? int'(CMDS[idx][7:0]) + 1 : 1;
    @(negedge gmii_rx_clk);
    rec_en = 1'b1;
    datain = {CMDS[idx][37:36], 2'b00, CMDS[idx][35:8]};
    for (j = 0; j < words; j++) begin
      @(negedge gmii_rx_clk);
      if (CMDS[idx][37:36] == RD_OP) begin
        datain = {24'h0, CMDS[idx][7:0]};
      end else begin
        datain = payload[idx*256 + j];
      end
    end
    @(negedge gmii_rx_clk);
    rec_en       = 1'b0;
    rec_pkt_done = 1'b1;
    @(negedge gmii_rx_clk);
    rec_pkt_done = 1'b0;
  endtask

  task automatic run_command(input int idx);
    logic [1:0] op;
    logic [9:0] base;
    int         len;
    int         j;
    int         bursts0;
    int         pulses0;
    op      = CMDS[idx][37:36];
    base    = CMDS[idx][17:8];
    len     = int'(CMDS[idx][7:0]);
    bursts0 = wr_bursts;
    pulses0 = tx_pulses;
    cur     = idx;
    cur_op  = op;
    if (op == WR_OP) begin
      for (j = 0; j <= len; j++) begin
        exp_mem[base + 10'(j)] = payload[idx*256 + j];
      end
    end
    send_packet(idx);
    if (op == WR_OP) begin
      while (!wr_data_valid) @(negedge gmii_rx_clk);
      while (wr_data_valid) @(negedge gmii_rx_clk);
    end else if (op == RD_OP) begin
      while (!tx_start_en) @(negedge gmii_rx_clk);
      for (j = 0; j <= len; j++) begin
        compare("udp_tx_data", udp_tx_data, exp_mem[base + 10'(j)]);
        tx_req = 1'b1;
        @(negedge gmii_rx_clk);
      end
      tx_req = 1'b0;
    end
    repeat (3) @(negedge gmii_rx_clk);
    compare("write bursts", wr_bursts - bursts0, (op == WR_OP) ? 1 : 0);
    compare("tx_start_en pulses", tx_pulses - pulses0, (op == RD_OP) ? 1 : 0);
  endtask

  // memory model slave, decides each transfer at the falling edge before it.
  initial begin : mem_slave
    int k;
    wr_addr_ready = 1'b0;
    wr_data_ready = 1'b0;
    rd_addr_ready = 1'b0;
    rd_data       = '0;
    rd_back_ID    = 4'h0;
    rd_data_last  = 1'b0;
    rd_data_valid = 1'b0;
    wa            = '0;
    ra            = '0;
    wbeat         = 0;
    rbeat         = 0;
    rlen          = 0;
    rd_active     = 1'b0;
    rd_xfer       = 1'b0;
    wr_bursts     = 0;
    tx_pulses     = 0;
    for (k = 0; k < 1024; k++) begin
      mem[k] = 32'hc0de_0000 + k;
    end
    forever begin
      @(negedge gmii_rx_clk);
      if (rstn) begin
        if (tx_start_en) begin
          tx_pulses++;
        end
        // a bus that the current packet does not use stays quiet.
        if (cur_op != WR_OP) begin
          compare("wr_addr_valid", 32'(wr_addr_valid), 0);
          compare("wr_data_valid", 32'(wr_data_valid), 0);
        end
        if (cur_op != RD_OP) begin
          compare("rd_addr_valid", 32'(rd_addr_valid), 0);
          compare("rd_data_ready", 32'(rd_data_ready), 0);
          compare("tx_start_en", 32'(tx_start_en), 0);
        end
        wr_data_ready = ($random(seed) % 4) != 0;
        if (wr_data_valid && wr_data_ready) begin
          compare("wr_data", wr_data, payload[cur*256 + wbeat]);
          compare("wr_strb", 32'(wr_strb), 32'hf);
          compare("wr_data_last", 32'(wr_data_last),
                  32'(wbeat == int'(CMDS[cur][7:0])));
          mem[wa + 10'(wbeat)] = wr_data;
          if (wr_data_last) begin
            wr_bursts++;
          end
          wbeat++;
        end
        wr_addr_ready = ($random(seed) % 2) == 0;
        if (wr_addr_valid && wr_addr_ready) begin
          compare("wr_addr", 32'(wr_addr), 32'(CMDS[cur][35:8]));
          compare("wr_ID", 32'(wr_ID), 32'(DUT_ID));
          compare("wr_len", 32'(wr_len), 32'(CMDS[cur][7:0]));
          wa    = wr_addr[9:0];
          wbeat = 0;
        end
        // beat offered last time went through on the rising edge between.
        if (rd_xfer) begin
          rbeat++;
        end
        if (rbeat > rlen) begin
          rd_active = 1'b0;
        end
        if (!rd_data_valid || rd_xfer) begin
          rd_data_valid = rd_active && (($random(seed) % 3) != 0);
        end
        rd_data       = mem[ra + 10'(rbeat)];
        rd_data_last  = rd_data_valid && (rbeat == rlen);
        rd_xfer       = rd_data_valid && rd_data_ready;
        rd_addr_ready = ($random(seed) % 2) == 0;
        if (rd_addr_valid && rd_addr_ready) begin
          compare("rd_addr", 32'(rd_addr), 32'(CMDS[cur][35:8]));
          compare("rd_ID", 32'(rd_ID), 32'(DUT_ID));
          compare("rd_len", 32'(rd_len), 32'(CMDS[cur][7:0]));
          ra        = rd_addr[9:0];
          rlen      = int'(rd_len);
          rbeat     = 0;
          rd_active = 1'b1;
        end
      end
    end
  end

  initial begin
    int i;
    int k;
    seed         = 16708;
    rstn         = 1'b0;
    rec_en       = 1'b0;
    rec_pkt_done = 1'b0;
    datain       = '0;
    tx_req       = 1'b0;
    cur          = 0;
    cur_op       = 2'b00;
    for (k = 0; k < 1024; k++) begin
      exp_mem[k] = 32'hc0de_0000 + k;
    end
    for (i = 0; i < NUM; i++) begin
      limit = limit + 8 * (int'(CMDS[i][7:0]) + 2);
      for (k = 0; k < 256; k++) begin
        payload[i*256 + k] = $random(seed);
      end
    end
    repeat (5) @(negedge gmii_rx_clk);
    rstn = 1'b1;
    @(negedge gmii_rx_clk);
    compare("wr_addr_valid", 32'(wr_addr_valid), 0);
    compare("wr_data_valid", 32'(wr_data_valid), 0);
    compare("rd_addr_valid", 32'(rd_addr_valid), 0);
    compare("rd_data_ready", 32'(rd_data_ready), 0);
    compare("tx_start_en", 32'(tx_start_en), 0);
    for (i = 0; i < NUM; i++) begin
      run_command(i);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/axi_udp_cmd.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_udp_cmd
  import udp_cmd_pkg::*;
#(
  parameter logic [ID_W-1:0] ID      = '0,
  parameter int              FIFO_AW = 8
) (
  input  wire               gmii_rx_clk,
  input  wire               rstn,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [ID_W-1:0]   wr_ID,
  output logic [LEN_W-1:0]  wr_len,
  output logic              wr_addr_valid,
  input  wire               wr_addr_ready,
  output logic [31:0]       wr_data,
  output logic [3:0]        wr_strb,
  output logic              wr_data_valid,
  input  wire               wr_data_ready,
  output logic              wr_data_last,
  output logic [ADDR_W-1:0] rd_addr,
  output logic [ID_W-1:0]   rd_ID,
  output logic [LEN_W-1:0]  rd_len,
  output logic              rd_addr_valid,
  input  wire               rd_addr_ready,
  input  wire  [31:0]       rd_data,
  input  wire  [ID_W-1:0]   rd_back_ID,
  input  wire               rd_data_last,
  output logic              rd_data_ready,
  input  wire               rd_data_valid,
  input  wire               rec_pkt_done,
  input  wire  [31:0]       datain,
  input  wire               rec_en,
  input  wire               tx_req,
  output logic              tx_start_en,
  output logic [31:0]       udp_tx_data
);

  logic             fifo_push;
  logic             fifo_pop;
  logic             fifo_empty;
  logic             buf_clear;
  logic             buf_push;
  logic             buf_empty;
  logic             cnt_clear;
  logic             cnt_inc;
  logic [LEN_W-1:0] cnt_limit;
  logic [LEN_W-1:0] cnt_value;
  logic             cnt_last;

  // full words only.
  assign wr_strb = 4'hf;

  cmd_fsm #(.ID(ID)) u_cmd_fsm (.*);

  beat_counter u_beat_counter (.*);

  wr_payload_fifo #(.FIFO_AW(FIFO_AW)) u_wr_payload_fifo (
    .gmii_rx_clk (gmii_rx_clk),
    .rstn        (rstn),
    .fifo_push   (fifo_push),
    .datain      (datain),
    .fifo_pop    (fifo_pop),
    .fifo_data   (wr_data),
    .fifo_empty  (fifo_empty)
  );

  rd_resp_buffer #(.FIFO_AW(FIFO_AW)) u_rd_resp_buffer (.*);

endmodule

`default_nettype wire

/* hdl/cmd_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_fsm
  import udp_cmd_pkg::*;
#(
  parameter logic [ID_W-1:0] ID = '0
) (
  input  wire               gmii_rx_clk,
  input  wire               rstn,
  input  wire               rec_en,
  input  wire  [31:0]       datain,
  input  wire               rec_pkt_done,
  input  wire               wr_addr_ready,
  input  wire               wr_data_ready,
  input  wire               rd_addr_ready,
  input  wire               rd_data_valid,
  input  wire               rd_data_last,
  input  wire  [ID_W-1:0]   rd_back_ID,
  input  wire               tx_req,
  input  wire               fifo_empty,
  input  wire               buf_empty,
  input  wire  [LEN_W-1:0]  cnt_value,
  input  wire               cnt_last,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [ID_W-1:0]   wr_ID,
  output logic [LEN_W-1:0]  wr_len,
  output logic              wr_addr_valid,
  output logic              wr_data_valid,
  output logic              wr_data_last,
  output logic [ADDR_W-1:0] rd_addr,
  output logic [ID_W-1:0]   rd_ID,
  output logic [LEN_W-1:0]  rd_len,
  output logic              rd_addr_valid,
  output logic              rd_data_ready,
  output logic              tx_start_en,
  output logic              fifo_push,
  output logic              fifo_pop,
  output logic              buf_clear,
  output logic              buf_push,
  output logic              cnt_clear,
  output logic              cnt_inc,
  output logic [LEN_W-1:0]  cnt_limit
);

  fsm_state_e        state;
  logic [1:0]        op;
  logic [ADDR_W-1:0] addr;
  logic              got_word;
  cmd_word_u         word;
  logic              is_wr;
  logic              is_rd;
  logic              wr_beat;
  logic              rd_beat;

  assign word  = datain;
  assign is_wr = (op == OP_WRITE);
  assign is_rd = (op == OP_READ);

  assign wr_addr       = addr;
  assign rd_addr       = addr;
  assign wr_ID         = ID;
  assign rd_ID         = ID;
  assign wr_addr_valid = (state == S_WR_ADDR);
  assign wr_data_valid = (state == S_WR_DATA) && !fifo_empty;
  assign wr_data_last  = wr_data_valid && cnt_last;
  assign rd_addr_valid = (state == S_RD_ADDR);
  assign rd_data_ready = (state == S_RD_DATA);
  assign wr_beat       = wr_data_valid && wr_data_ready;
  assign rd_beat       = rd_data_valid && rd_data_ready;

  assign fifo_push = (state == S_RX) && rec_en && is_wr;
  assign fifo_pop  = wr_beat;
  assign buf_clear = rd_addr_valid;
  assign buf_push  = rd_beat;

  // the first payload word is not counted, so the count ends at wr_len.
  assign cnt_clear = (state == S_IDLE) || ((state == S_RX) && rec_pkt_done);
  assign cnt_inc   = (fifo_push && got_word) || ((wr_beat || rd_beat) && !cnt_last);
  assign cnt_limit = is_rd ? rd_len : wr_len;

  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      state       <= S_IDLE;
      op          <= '0;
      got_word    <= 1'b0;
      tx_start_en <= 1'b0;
    end else begin
      tx_start_en <= 1'b0;
      case (state)
        S_IDLE: begin
          got_word <= 1'b0;
          op       <= datain[31:30];
          // a header alone is never a complete command.
          if (rec_en && !rec_pkt_done) begin
            state <= S_RX;
          end
        end
        S_RX: begin
          if (rec_en) begin
            got_word <= 1'b1;
          end
          if (rec_pkt_done) begin
            if (is_wr && (got_word || rec_en)) begin
              state <= S_WR_ADDR;
            end else if (is_rd && (got_word || rec_en)) begin
              state <= S_RD_ADDR;
            end else begin
              state <= S_IDLE;
            end
          end
        end
        S_WR_ADDR: if (wr_addr_ready) state <= S_WR_DATA;
        S_WR_DATA: if (wr_beat && cnt_last) state <= S_IDLE;
        S_RD_ADDR: if (rd_addr_ready) state <= S_RD_DATA;
        S_RD_DATA: begin
          if (rd_beat && rd_data_last) begin
            state       <= S_TX;
            tx_start_en <= 1'b1;
          end
        end
        S_TX: if (buf_empty) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if ((state == S_IDLE) && rec_en) begin
      addr <= datain[ADDR_W-1:0];
    end
    if ((state == S_RX) && rec_en && !got_word) begin
      rd_len <= word.len.rd_len;
    end
    if ((state == S_RX) && rec_pkt_done) begin
      wr_len <= cnt_value + LEN_W'(got_word && rec_en);
    end
  end

  a_wr_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    wr_addr_valid && !wr_addr_ready |=> wr_addr_valid && $stable({wr_addr, wr_len}));

  a_wr_data_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    wr_data_valid && !wr_data_ready |=> wr_data_valid && $stable(wr_data_last));

  a_rd_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable({rd_addr, rd_len}));

  a_rd_id: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    rd_beat |-> (rd_back_ID == ID));

  // slave must close the burst on beat rd_len.
  a_rd_last: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    rd_beat |-> (rd_data_last == cnt_last));

  a_tx_req: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    tx_req |-> (state == S_TX));

endmodule

`default_nettype wire

/* hdl/rd_resp_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module rd_resp_buffer #(
  parameter int FIFO_AW = 8
) (
  input  wire         gmii_rx_clk,
  input  wire         rstn,
  input  wire         buf_clear,
  input  wire         buf_push,
  input  wire  [31:0] rd_data,
  input  wire         tx_req,
  output logic [31:0] udp_tx_data,
  output logic        buf_empty
);

  logic [31:0]      mem [2**FIFO_AW];
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;

  // cleared before each read burst.
  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (buf_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (buf_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (tx_req) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (buf_push) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= rd_data;
    end
  end

  // head word is on the udp side until tx_req takes it.
  assign udp_tx_data = mem[rd_ptr[FIFO_AW-1:0]];
  assign buf_empty   = (wr_ptr == rd_ptr);

  a_tx_not_empty: assert property (
    @(posedge gmii_rx_clk) disable iff (!rstn)
    tx_req |-> !buf_empty
  );

endmodule

`default_nettype wire

/* hdl/wr_payload_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module wr_payload_fifo #(
  parameter int FIFO_AW = 8
) (
  input  wire         gmii_rx_clk,
  input  wire         rstn,
  input  wire         fifo_push,
  input  wire  [31:0] datain,
  input  wire         fifo_pop,
  output logic [31:0] fifo_data,
  output logic        fifo_empty
);

  logic [31:0]      mem [2**FIFO_AW];
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic             full;

  // extra pointer bit tells full from empty.
  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (fifo_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (fifo_push) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= datain;
    end
  end

  // show-ahead, the head word drives the write data bus.
  assign fifo_data  = mem[rd_ptr[FIFO_AW-1:0]];
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign full       = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                      (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  a_no_overflow: assert property (
    @(posedge gmii_rx_clk) disable iff (!rstn)
    !(fifo_push && full)
  );

  a_no_underflow: assert property (
    @(posedge gmii_rx_clk) disable iff (!rstn)
    !(fifo_pop && fifo_empty)
  );

endmodule

`default_nettype wire

/* hdl/beat_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module beat_counter
  import udp_cmd_pkg::*;
(
  input  wire              gmii_rx_clk,
  input  wire              rstn,
  input  wire              cnt_clear,
  input  wire              cnt_inc,
  input  wire [LEN_W-1:0]  cnt_limit,
  output logic [LEN_W-1:0] cnt_value,
  output logic             cnt_last
);

  // clear wins over increment.
  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      cnt_value <= '0;
    end else if (cnt_clear) begin
      cnt_value <= '0;
    end else if (cnt_inc) begin
      cnt_value <= cnt_value + 1'b1;
    end
  end

  assign cnt_last = (cnt_value == cnt_limit);

  // a burst of 256 beats tops out at 255, never wraps.
  a_no_wrap: assert property (
    @(posedge gmii_rx_clk) disable iff (!rstn)
    !(cnt_inc && !cnt_clear && (cnt_value == '1))
  );

endmodule

`default_nettype wire

/* hdl/udp_cmd_pkg.sv */
`default_nettype none

package udp_cmd_pkg;

  // header op codes in bits 31..30, other values are dropped.
  typedef enum logic [1:0] {
    OP_WRITE = 2'b10,
    OP_READ  = 2'b01
  } op_e;

  localparam int ADDR_W = 28;
  localparam int LEN_W  = 8;
  localparam int ID_W   = 4;

  // second word of a packet, payload for writes and length for reads.
  typedef union packed {
    logic [31:0] data;
    struct packed {
      logic [23:0]      rsvd;
      logic [LEN_W-1:0] rd_len;
    } len;
  } cmd_word_u;

  typedef enum logic [2:0] {
    S_IDLE,
    S_RX,
    S_WR_ADDR,
    S_WR_DATA,
    S_RD_ADDR,
    S_RD_DATA,
    S_TX
  } fsm_state_e;

endpackage

`default_nettype wire
